// File: dv/cpu_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core_assert (
	input logic                     clk_i,
	input logic                     rst_i,
	input cpu_pipe_pkg::ibus_req_t  ibus_req_i,
	input cpu_pipe_pkg::ibus_resp_t ibus_resp_i,
	input cpu_pipe_pkg::dbus_req_t  dbus_req_i,
	input cpu_pipe_pkg::dbus_resp_t dbus_resp_i
);

// boot address and idle data bus right out of reset
reset_state: assert property (@(posedge clk_i) $fell(rst_i) |->
	ibus_req_i.address == `CPU_RESET_PC && !dbus_req_i.read && !dbus_req_i.write)
	else $error("core not idle at the boot address after reset");

// a refused fetch keeps its address
ibus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
	ibus_req_i.read && ibus_resp_i.stall |=> $stable(ibus_req_i.address))
	else $error("ibus address moved while the bus was stalled");

dbus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
	dbus_resp_i.stall |=> $stable(dbus_req_i))
	else $error("dbus request changed while the bus was stalled");

dbus_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
	!(dbus_req_i.read && dbus_req_i.write))
	else $error("dbus read and write high in the same cycle");

endmodule

bind cpu_core cpu_core_assert protocol0 (
	.clk_i       ( clk         ),
	.rst_i       ( rst         ),
	.ibus_req_i  ( ibus_req_o  ),
	.ibus_resp_i ( ibus_resp_i ),
	.dbus_req_i  ( dbus_req_o  ),
	.dbus_resp_i ( dbus_resp_i )
);

`default_nettype wire

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core_tb;

localparam int PROG_LEN = 400;
localparam int SEED     = 32'hb42f;

localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_ORI     = 6'h0d;
localparam logic [5:0] OPC_LUI     = 6'h0f;
localparam logic [5:0] OPC_LW      = 6'h23;
localparam logic [5:0] OPC_SW      = 6'h2b;
// addu subu and or xor slt
localparam logic [35:0] ALU_FUNCTS = {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};

typedef struct packed {
	logic [31:0] addr;
	logic [31:0] data;
} store_rec_t;

logic                     clk;
logic                     rst;
cpu_pipe_pkg::ibus_req_t  ibus_req;
cpu_pipe_pkg::ibus_req_t  ibus_req_prev;
cpu_pipe_pkg::ibus_resp_t ibus_resp;
cpu_pipe_pkg::dbus_req_t  dbus_req;
cpu_pipe_pkg::dbus_req_t  dbus_req_prev;
cpu_pipe_pkg::dbus_resp_t dbus_resp;

logic [31:0] rom [PROG_LEN];
logic [31:0] dmem [1024];
logic [31:0] ref_mem [1024];
logic [31:0] ref_regs [32];
int          prog_len;
store_rec_t  exp_q [$];
store_rec_t  exp_head;
int          exp_left;
int          fetch_count;
logic [31:0] last_fetch_addr;
logic        fetch_accept;
logic        store_fire;

tb_clock clk_gen0 (
	.clk_o ( clk ),
	.rst_o ( rst )
);

cpu_core dut0 (
	.clk,
	.rst,
	.ibus_req_o  ( ibus_req  ),
	.ibus_resp_i ( ibus_resp ),
	.dbus_req_o  ( dbus_req  ),
	.dbus_resp_i ( dbus_resp )
);

assign fetch_accept = ibus_req.read & ~ibus_resp.stall;
assign store_fire   = dbus_req.write & ~dbus_resp.stall;

task automatic stop_with_failure(input string why);
	$display("%s", why);
	$display("TEST RESULT: FAIL");
	$fatal(1);
endtask

task automatic report_mismatch(input string sig, input logic [65:0] got,
	input logic [65:0] exp);
	stop_with_failure($sformatf("Mismatch at %0t: %s got %0h, expected %0h",
		$time, sig, got, exp));
endtask

function automatic logic [31:0] fill_word(input logic [9:0] idx);
	return {idx, 6'h15, ~idx, 6'h2a};
endfunction

// past the program the ROM reads as sll r0, r0, 0
function automatic logic [31:0] fetch_word(input logic [31:0] addr);
	logic [31:0] off;
	off = addr - `CPU_RESET_PC;
	if (off[31:2] < 30'(prog_len)) begin
		return rom[off[31:2]];
	end
	return 32'h0;
endfunction

// ISA reference stepping one instruction in program order
task automatic model_step(input logic [31:0] instr);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] res;
	logic [4:0]  dst;
	a    = ref_regs[instr[25:21]];
	b    = ref_regs[instr[20:16]];
	simm = {{16{instr[15]}}, instr[15:0]};
	dst  = 5'd0;
	res  = '0;
	case (instr[31:26])
		OPC_SPECIAL: begin
			dst = instr[15:11];
			case (instr[5:0])
				6'h21: res = a + b;
				6'h23: res = a - b;
				6'h24: res = a & b;
				6'h25: res = a | b;
				6'h26: res = a ^ b;
				6'h2a: res = {31'b0, $signed(a) < $signed(b)};
				default: dst = 5'd0;
			endcase
		end
		OPC_ADDIU: begin
			dst = instr[20:16];
			res = a + simm;
		end
		OPC_ORI: begin
			dst = instr[20:16];
			res = a | {16'h0, instr[15:0]};
		end
		OPC_LUI: begin
			dst = instr[20:16];
			res = {instr[15:0], 16'h0};
		end
		OPC_LW: begin
			dst = instr[20:16];
			res = ref_mem[(a + simm) >> 2 & 32'h3ff];
		end
		OPC_SW: begin
			ref_mem[(a + simm) >> 2 & 32'h3ff] = b;
			exp_q.push_back({a + simm, b});
		end
		default: begin
		end
	endcase
	if (dst != 5'd0) begin
		ref_regs[dst] = res;
	end
endtask

task automatic emit(input logic [31:0] instr);
	rom[prog_len] = instr;
	prog_len++;
	model_step(instr);
endtask

// random ALU, lui, lw and sw mix over r0..r7 so dependencies come often
task automatic gen_program();
	logic [4:0]  rd;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  base;
	logic [4:0]  dst;
	logic [4:0]  last_rd;
	logic [5:0]  op;
	logic [15:0] off;
	int          kind;
	int          fn_sel;
	last_rd = 5'd1;
	while (prog_len < PROG_LEN - 12) begin
		kind   = $urandom_range(9);
		fn_sel = $urandom_range(5);
		rd     = 5'($urandom_range(7));
		rs     = ($urandom_range(1) == 0) ? last_rd : 5'($urandom_range(7));
		rt     = 5'($urandom_range(7));
		base   = ($urandom_range(1) == 0) ? 5'd0 : 5'($urandom_range(7));
		off    = {8'h0, 6'($urandom_range(63)), 2'b00};
		op     = ($urandom_range(1) == 0) ? OPC_ADDIU : OPC_ORI;
		case (kind)
			0, 1, 2, 3: begin
				emit({OPC_SPECIAL, rs, rt, rd, 5'h0, ALU_FUNCTS[fn_sel * 6 +: 6]});
				last_rd = rd;
			end
			4: begin
				emit({op, rs, rd, 16'($urandom)});
				last_rd = rd;
			end
			5: begin
				emit({OPC_LUI, 5'h0, rd, 16'($urandom)});
				last_rd = rd;
			end
			6: begin
				emit({OPC_LW, base, rd, off});
				last_rd = rd;
			end
			7: emit({OPC_SW, base, rs, off});
			8: begin
				// consumer right behind the load and a store of its result
				rd  = 5'($urandom_range(7, 1));
				dst = 5'($urandom_range(7, 1));
				emit({OPC_LW, base, rd, off});
				emit({OPC_SPECIAL, rd, rt, dst, 5'h0, 6'h21});
				emit({OPC_SW, 5'd0, dst, off ^ 16'h0100});
				last_rd = dst;
			end
			default: begin
				emit({OPC_ADDIU, rs, 5'd0, 16'($urandom)});
				// unsupported opcode
				emit({6'h3f, 26'($urandom)});
				emit({OPC_SW, base, 5'd0, off});
			end
		endcase
	end
	for (int r = 1; r < 8; r++) begin
		emit({OPC_SW, 5'd0, 5'(r), 16'(r * 4 + 16'h0200)});
	end
endtask

// instruction ROM answers one cycle after an accepted read
always @(posedge clk) begin
	if (rst) begin
		ibus_resp <= '0;
	end else begin
		ibus_resp.valid  <= fetch_accept;
		ibus_resp.rddata <= fetch_word(ibus_req.address);
		ibus_resp.stall  <= ($urandom_range(3) == 0);
	end
end

// data RAM returns load data one cycle after the accepted read
always @(posedge clk) begin
	if (rst) begin
		dbus_resp <= '0;
	end else begin
		if (store_fire) begin
			dmem[dbus_req.address[11:2]] <= dbus_req.wdata;
		end
		if (dbus_req.read && !dbus_resp.stall) begin
			dbus_resp.rddata <= dmem[dbus_req.address[11:2]];
		end
		dbus_resp.stall <= ($urandom_range(3) == 0);
	end
end

always @(posedge clk) begin
	if (!rst && store_fire && exp_q.size() != 0) begin
		void'(exp_q.pop_front());
		exp_left <= exp_q.size();
		exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
	end
end

always @(posedge clk) begin
	ibus_req_prev <= ibus_req;
	dbus_req_prev <= dbus_req;
	if (rst) begin
		fetch_count <= 0;
	end else if (fetch_accept) begin
		fetch_count     <= fetch_count + 1;
		last_fetch_addr <= ibus_req.address;
	end
end

first_fetch: assert property (@(posedge clk) disable iff (rst)
	fetch_accept && fetch_count == 0 |-> ibus_req.address == `CPU_RESET_PC)
	else report_mismatch("ibus_req.address", $sampled(ibus_req.address), `CPU_RESET_PC);

reset_idle: assert property (@(posedge clk)
	$fell(rst) |-> !dbus_req.read && !dbus_req.write)
	else stop_with_failure("dbus request active in the first cycle after reset");

fetch_step: assert property (@(posedge clk) disable iff (rst)
	fetch_accept && fetch_count != 0 |-> ibus_req.address == last_fetch_addr + 32'd4)
	else report_mismatch("ibus_req.address", $sampled(ibus_req.address),
		$sampled(last_fetch_addr) + 32'd4);

fetch_hold: assert property (@(posedge clk) disable iff (rst)
	ibus_req.read && ibus_resp.stall |=> ibus_req.address == ibus_req_prev.address)
	else report_mismatch("ibus_req.address", $sampled(ibus_req.address),
		$sampled(ibus_req_prev.address));

store_expected: assert property (@(posedge clk) disable iff (rst)
	store_fire |-> exp_left != 0)
	else stop_with_failure("dbus write seen after every store of the program completed");

store_addr: assert property (@(posedge clk) disable iff (rst)
	store_fire |-> dbus_req.address == exp_head.addr)
	else report_mismatch("dbus_req.address", $sampled(dbus_req.address),
		$sampled(exp_head.addr));

store_data: assert property (@(posedge clk) disable iff (rst)
	store_fire |-> dbus_req.wdata == exp_head.data)
	else report_mismatch("dbus_req.wdata", $sampled(dbus_req.wdata),
		$sampled(exp_head.data));

dbus_hold: assert property (@(posedge clk) disable iff (rst)
	dbus_resp.stall |=> dbus_req == dbus_req_prev)
	else report_mismatch("dbus_req", $sampled(dbus_req), $sampled(dbus_req_prev));

dbus_exclusive: assert property (@(posedge clk) disable iff (rst)
	!(dbus_req.read && dbus_req.write))
	else stop_with_failure("dbus read and write asserted in the same cycle");

initial begin
	#(PROG_LEN * 40 * 8);
	stop_with_failure("watchdog expired with stores still outstanding");
end

initial begin
	void'($urandom(SEED));
	ibus_resp = '0;
	dbus_resp = '0;
	prog_len  = 0;
	for (int i = 0; i < 1024; i++) begin
		dmem[i]    = fill_word(10'(i));
		ref_mem[i] = fill_word(10'(i));
	end
	for (int i = 0; i < 32; i++) begin
		ref_regs[i] = '0;
	end
	gen_program();
	exp_head = exp_q[0];
	exp_left = exp_q.size();
	while (exp_left != 0) begin
		@(posedge clk);
	end
	repeat (16) @(posedge clk);
	// only nops remain in the pipeline by now
	if (!dbus_req.read && !dbus_req.write) begin
		$display("TEST RESULT: PASS");
		$finish;
	end else begin
		stop_with_failure("data bus still active after the program drained");
	end
end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic rst_o
);

// 8 ns period
initial begin
	clk_o = 1'b0;
	forever begin
		#4 clk_o = ~clk_o;
	end
end

initial begin
	rst_o = 1'b1;
	repeat (2) @(posedge clk_o);
	rst_o <= 1'b0;
end

endmodule

`default_nettype wire

// File: rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// address of the first fetch after reset
`define CPU_RESET_PC 32'hbfc00000

// architectural general purpose registers
`define CPU_REG_NUM 32

`endif

// File: rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input  logic                     clk,
	input  logic                     rst,
	output cpu_pipe_pkg::ibus_req_t  ibus_req_o,
	input  cpu_pipe_pkg::ibus_resp_t ibus_resp_i,
	output cpu_pipe_pkg::dbus_req_t  dbus_req_o,
	input  cpu_pipe_pkg::dbus_resp_t dbus_resp_i
);

// stall and flush
logic stall_from_id;
logic stall_mm;
logic stall_if;
logic flush_ex;

cpu_isa_pkg::reg_addr_t [1:0] reg_raddr;
cpu_isa_pkg::uint32_t   [1:0] reg_rdata;

cpu_pipe_pkg::fetch_entry_t     if_fetch_entry;
cpu_pipe_pkg::pipeline_decode_t pipeline_decode;
cpu_pipe_pkg::pipeline_decode_t pipeline_decode_d;
cpu_pipe_pkg::pipeline_exec_t   pipeline_exec;
cpu_pipe_pkg::pipeline_exec_t   pipeline_exec_d;
cpu_pipe_pkg::pipeline_memwb_t  pipeline_mem;
cpu_pipe_pkg::pipeline_memwb_t  pipeline_mem_fwd;
cpu_pipe_pkg::pipeline_memwb_t  pipeline_wb;
cpu_pipe_pkg::pipeline_memwb_t  pipeline_wb_fwd;
logic                           wb_is_load;
cpu_isa_pkg::uint32_t           wb_wdata;

// dbus stall freezes every stage, load-use only holds IF/ID
assign stall_mm = dbus_resp_i.stall;
assign stall_if = stall_from_id | stall_mm;
assign flush_ex = stall_from_id & ~stall_mm;

regfile regfile_inst (
	.clk,
	.rst,
	.raddr_i ( reg_raddr         ),
	.rdata_o ( reg_rdata         ),
	.waddr_i ( pipeline_wb.rd    ),
	.wdata_i ( wb_wdata          )
);

instr_fetch instr_fetch_inst (
	.clk,
	.rst,
	.stall_i       ( stall_if       ),
	.ibus_req_o    ( ibus_req_o     ),
	.ibus_resp_i   ( ibus_resp_i    ),
	.fetch_entry_o ( if_fetch_entry )
);

decode_and_issue decode_issue_inst (
	.fetch_entry_i ( if_fetch_entry    ),
	.pipe_ex_i     ( pipeline_decode_d ),
	.reg_raddr_o   ( reg_raddr         ),
	.reg_rdata_i   ( reg_rdata         ),
	.decode_o      ( pipeline_decode   ),
	.stall_o       ( stall_from_id     )
);

// ID/EX, bubble on load-use
always_ff @(posedge clk) begin
	if (rst || flush_ex) begin
		pipeline_decode_d <= '0;
	end else if (~stall_mm) begin
		pipeline_decode_d <= pipeline_decode;
	end
end

instr_exec exec_inst (
	.data_i     ( pipeline_decode_d ),
	.pipe_mem_i ( pipeline_mem_fwd  ),
	.pipe_wb_i  ( pipeline_wb_fwd   ),
	.result_o   ( pipeline_exec     )
);

// EX/MEM
always_ff @(posedge clk) begin
	if (rst) begin
		pipeline_exec_d <= '0;
	end else if (~stall_mm) begin
		pipeline_exec_d <= pipeline_exec;
	end
end

assign dbus_req_o.read    = pipeline_exec_d.is_load;
assign dbus_req_o.write   = pipeline_exec_d.is_store;
assign dbus_req_o.address = pipeline_exec_d.result;
assign dbus_req_o.wdata   = pipeline_exec_d.store_data;

assign pipeline_mem.rd    = pipeline_exec_d.rd;
assign pipeline_mem.wdata = pipeline_exec_d.result;

// load value is not known until WB
assign pipeline_mem_fwd.rd    = pipeline_exec_d.is_load ? '0 : pipeline_exec_d.rd;
assign pipeline_mem_fwd.wdata = pipeline_exec_d.result;

// MEM/WB
// on a freeze the merged value is kept, rddata may move on
always_ff @(posedge clk) begin
	if (rst) begin
		pipeline_wb <= '0;
		wb_is_load  <= 1'b0;
	end else if (stall_mm) begin
		pipeline_wb.wdata <= wb_wdata;
		wb_is_load        <= 1'b0;
	end else begin
		pipeline_wb <= pipeline_mem;
		wb_is_load  <= pipeline_exec_d.is_load;
	end
end

assign wb_wdata = wb_is_load ? dbus_resp_i.rddata : pipeline_wb.wdata;

assign pipeline_wb_fwd.rd    = pipeline_wb.rd;
assign pipeline_wb_fwd.wdata = wb_wdata;

endmodule

`default_nettype wire

// File: rtl/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [2:0]  alu_op_t;

	// primary opcodes
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	// SPECIAL function field
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_SLT  = 6'h2a;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLT = 3'd5;
	localparam alu_op_t ALU_LUI = 3'd6;

endpackage

`default_nettype wire

// File: rtl/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	typedef struct packed {
		logic                 read;
		cpu_isa_pkg::uint32_t address;
	} ibus_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 stall;
		cpu_isa_pkg::uint32_t rddata;
	} ibus_resp_t;

	typedef struct packed {
		logic                 read;
		logic                 write;
		cpu_isa_pkg::uint32_t address;
		cpu_isa_pkg::uint32_t wdata;
	} dbus_req_t;

	typedef struct packed {
		logic                 stall;
		cpu_isa_pkg::uint32_t rddata;
	} dbus_resp_t;

	typedef struct packed {
		logic                 valid;
		cpu_isa_pkg::uint32_t pc;
		cpu_isa_pkg::uint32_t instr;
	} fetch_entry_t;

	// ID -> EX
	typedef struct packed {
		logic                   valid;
		cpu_isa_pkg::reg_addr_t rd;
		cpu_isa_pkg::reg_addr_t rs;
		cpu_isa_pkg::reg_addr_t rt;
		cpu_isa_pkg::uint32_t   rs_data;
		cpu_isa_pkg::uint32_t   rt_data;
		cpu_isa_pkg::uint32_t   imm;
		cpu_isa_pkg::alu_op_t   alu_op;
		logic                   use_imm;
		logic                   is_load;
		logic                   is_store;
	} pipeline_decode_t;

	// EX -> MEM, result is the address for loads and stores
	typedef struct packed {
		cpu_isa_pkg::reg_addr_t rd;
		cpu_isa_pkg::uint32_t   result;
		cpu_isa_pkg::uint32_t   store_data;
		logic                   is_load;
		logic                   is_store;
	} pipeline_exec_t;

	typedef struct packed {
		cpu_isa_pkg::reg_addr_t rd;
		cpu_isa_pkg::uint32_t   wdata;
	} pipeline_memwb_t;

endpackage

`default_nettype wire

// File: rtl/decode_and_issue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_and_issue (
	input  cpu_pipe_pkg::fetch_entry_t       fetch_entry_i,
	input  cpu_pipe_pkg::pipeline_decode_t   pipe_ex_i,
	output cpu_isa_pkg::reg_addr_t     [1:0] reg_raddr_o,
	input  cpu_isa_pkg::uint32_t       [1:0] reg_rdata_i,
	output cpu_pipe_pkg::pipeline_decode_t   decode_o,
	output logic                             stall_o
);

cpu_isa_pkg::uint32_t   instr;
cpu_isa_pkg::opcode_t   opcode;
cpu_isa_pkg::funct_t    funct;
cpu_isa_pkg::reg_addr_t rs;
cpu_isa_pkg::reg_addr_t rt;
cpu_isa_pkg::reg_addr_t rd;
logic [15:0]            imm16;
logic                   use_rs;
logic                   use_rt;
logic                   load_in_ex;

assign instr  = fetch_entry_i.instr;
assign opcode = instr[31:26];
assign rs     = instr[25:21];
assign rt     = instr[20:16];
assign rd     = instr[15:11];
assign imm16  = instr[15:0];
assign funct  = instr[5:0];

assign reg_raddr_o[0] = rs;
assign reg_raddr_o[1] = rt;

always_comb begin
	decode_o         = '0;
	use_rs           = 1'b0;
	use_rt           = 1'b0;
	decode_o.valid   = fetch_entry_i.valid;
	decode_o.rs      = rs;
	decode_o.rt      = rt;
	decode_o.rs_data = reg_rdata_i[0];
	decode_o.rt_data = reg_rdata_i[1];
	decode_o.imm     = {{16{imm16[15]}}, imm16};
	decode_o.alu_op  = cpu_isa_pkg::ALU_ADD;

	case (opcode)
		cpu_isa_pkg::OP_SPECIAL: begin
			use_rs      = 1'b1;
			use_rt      = 1'b1;
			decode_o.rd = rd;
			case (funct)
				cpu_isa_pkg::FN_ADDU: decode_o.alu_op = cpu_isa_pkg::ALU_ADD;
				cpu_isa_pkg::FN_SUBU: decode_o.alu_op = cpu_isa_pkg::ALU_SUB;
				cpu_isa_pkg::FN_AND:  decode_o.alu_op = cpu_isa_pkg::ALU_AND;
				cpu_isa_pkg::FN_OR:   decode_o.alu_op = cpu_isa_pkg::ALU_OR;
				cpu_isa_pkg::FN_XOR:  decode_o.alu_op = cpu_isa_pkg::ALU_XOR;
				cpu_isa_pkg::FN_SLT:  decode_o.alu_op = cpu_isa_pkg::ALU_SLT;
				default: begin
					// unsupported, retire as nop
					use_rs      = 1'b0;
					use_rt      = 1'b0;
					decode_o.rd = '0;
				end
			endcase
		end
		cpu_isa_pkg::OP_ADDIU: begin
			use_rs           = 1'b1;
			decode_o.rd      = rt;
			decode_o.use_imm = 1'b1;
		end
		cpu_isa_pkg::OP_ORI: begin
			use_rs           = 1'b1;
			decode_o.rd      = rt;
			decode_o.use_imm = 1'b1;
			decode_o.imm     = {16'h0, imm16};
			decode_o.alu_op  = cpu_isa_pkg::ALU_OR;
		end
		cpu_isa_pkg::OP_LUI: begin
			decode_o.rd      = rt;
			decode_o.use_imm = 1'b1;
			decode_o.alu_op  = cpu_isa_pkg::ALU_LUI;
		end
		cpu_isa_pkg::OP_LW: begin
			use_rs           = 1'b1;
			decode_o.rd      = rt;
			decode_o.use_imm = 1'b1;
			decode_o.is_load = 1'b1;
		end
		cpu_isa_pkg::OP_SW: begin
			use_rs            = 1'b1;
			use_rt            = 1'b1;
			decode_o.use_imm  = 1'b1;
			decode_o.is_store = 1'b1;
		end
		default: begin
		end
	endcase

	if (~fetch_entry_i.valid) begin
		decode_o = '0;
		use_rs   = 1'b0;
		use_rt   = 1'b0;
	end
end

// load data only shows up in WB, one bubble needed
assign load_in_ex = pipe_ex_i.valid & pipe_ex_i.is_load & (pipe_ex_i.rd != '0);
assign stall_o    = load_in_ex & ((use_rs & (pipe_ex_i.rd == rs)) |
	(use_rt & (pipe_ex_i.rd == rt)));

endmodule

`default_nettype wire

// File: rtl/instr_exec.sv
`timescale 1ns/1ps
`default_nettype none

module instr_exec (
	input  cpu_pipe_pkg::pipeline_decode_t data_i,
	input  cpu_pipe_pkg::pipeline_memwb_t  pipe_mem_i,
	input  cpu_pipe_pkg::pipeline_memwb_t  pipe_wb_i,
	output cpu_pipe_pkg::pipeline_exec_t   result_o
);

cpu_isa_pkg::uint32_t op_a;
cpu_isa_pkg::uint32_t op_rt;
cpu_isa_pkg::uint32_t op_b;
cpu_isa_pkg::uint32_t alu_out;

// youngest producer wins
function automatic cpu_isa_pkg::uint32_t forward(
	input cpu_isa_pkg::reg_addr_t src,
	input cpu_isa_pkg::uint32_t   reg_data
);
	if (pipe_mem_i.rd != '0 && pipe_mem_i.rd == src) begin
		return pipe_mem_i.wdata;
	end else if (pipe_wb_i.rd != '0 && pipe_wb_i.rd == src) begin
		return pipe_wb_i.wdata;
	end
	return reg_data;
endfunction

assign op_a  = forward(data_i.rs, data_i.rs_data);
assign op_rt = forward(data_i.rt, data_i.rt_data);
assign op_b  = data_i.use_imm ? data_i.imm : op_rt;

// loads and stores decode to add, giving base plus offset
always_comb begin
	case (data_i.alu_op)
		cpu_isa_pkg::ALU_SUB: alu_out = op_a - op_b;
		cpu_isa_pkg::ALU_AND: alu_out = op_a & op_b;
		cpu_isa_pkg::ALU_OR:  alu_out = op_a | op_b;
		cpu_isa_pkg::ALU_XOR: alu_out = op_a ^ op_b;
		cpu_isa_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
		cpu_isa_pkg::ALU_LUI: alu_out = {op_b[15:0], 16'h0};
		default:              alu_out = op_a + op_b;
	endcase
end

assign result_o.rd         = data_i.valid ? data_i.rd : '0;
assign result_o.result     = alu_out;
assign result_o.store_data = op_rt;
assign result_o.is_load    = data_i.valid & data_i.is_load;
assign result_o.is_store   = data_i.valid & data_i.is_store;

endmodule

`default_nettype wire

// File: rtl/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instr_fetch (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       stall_i,
	output cpu_pipe_pkg::ibus_req_t    ibus_req_o,
	input  cpu_pipe_pkg::ibus_resp_t   ibus_resp_i,
	output cpu_pipe_pkg::fetch_entry_t fetch_entry_o
);

cpu_isa_pkg::uint32_t       pc;
cpu_isa_pkg::uint32_t       resp_pc;
logic                       accepted;
logic                       hold_valid;
cpu_pipe_pkg::fetch_entry_t hold_entry;
cpu_pipe_pkg::fetch_entry_t resp_entry;

assign resp_entry.valid = ibus_resp_i.valid;
assign resp_entry.pc    = resp_pc;
assign resp_entry.instr = ibus_resp_i.rddata;

// held word goes first, bus never returns one while it is occupied
assign fetch_entry_o = hold_valid ? hold_entry : resp_entry;

// no new request while a word is about to be parked or is still parked
assign ibus_req_o.read    = ~stall_i | (~hold_valid & ~ibus_resp_i.valid);
assign ibus_req_o.address = pc;
assign accepted           = ibus_req_o.read & ~ibus_resp_i.stall;

always_ff @(posedge clk) begin
	if (rst) begin
		pc         <= `CPU_RESET_PC;
		hold_valid <= 1'b0;
	end else begin
		if (accepted) begin
			pc <= pc + 32'd4;
		end
		if (ibus_resp_i.valid & stall_i) begin
			hold_valid <= 1'b1;
		end else if (~stall_i) begin
			hold_valid <= 1'b0;
		end
	end
end

// pc of the word that answers next cycle
always_ff @(posedge clk) begin
	if (accepted) begin
		resp_pc <= pc;
	end
end

always_ff @(posedge clk) begin
	if (ibus_resp_i.valid & stall_i) begin
		hold_entry <= resp_entry;
	end
end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module regfile (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_isa_pkg::reg_addr_t [1:0] raddr_i,
	output cpu_isa_pkg::uint32_t   [1:0] rdata_o,
	input  cpu_isa_pkg::reg_addr_t       waddr_i,
	input  cpu_isa_pkg::uint32_t         wdata_i
);

cpu_isa_pkg::uint32_t regs [`CPU_REG_NUM];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `CPU_REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (waddr_i != '0) begin
		regs[waddr_i] <= wdata_i;
	end
end

// write-through so decode sees the value retiring this cycle
always_comb begin
	for (int p = 0; p < 2; p++) begin
		if (raddr_i[p] == '0) begin
			rdata_o[p] = '0;
		end else if (raddr_i[p] == waddr_i) begin
			rdata_o[p] = wdata_i;
		end else begin
			rdata_o[p] = regs[raddr_i[p]];
		end
	end
end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/regfile.sv
rtl/instr_fetch.sv
rtl/decode_and_issue.sv
rtl/instr_exec.sv
rtl/cpu_core.sv
dv/tb_clock.sv
dv/cpu_core_assert.sv
dv/cpu_core_tb.sv
